/* Makefile */
VERILATOR  ?= verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = +verilator+error+limit+100
TOP        = aesDecryptTb
FILELIST   = files.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/aesDecryptCore.sv */
/*
  AES-128 decryption sequencer. Walks the inverse rounds on a single
  state register, one column per cycle through the shared mixer
*/

`timescale 1ns/10ps
`include "aes_defines.svh"

module aesDecryptCore (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            run,
  input  aes_pkg::block_t msgIn,
  aesKeyIf.core           keyBus,
  output aes_pkg::word_t  mixIn,
  input  aes_pkg::word_t  mixOut,
  output aes_pkg::block_t msgOut,
  output logic            ready
);

  aes_pkg::coreState_t coreState;
  aes_pkg::block_t     dataBlock;
  aes_pkg::block_t     shiftSub;
  logic [3:0]          round;
  logic [1:0]          column;

  assign ready = (coreState == aes_pkg::IDLE);
  assign keyBus.start = ready && run;

  // Round 0 is the initial key addition, which takes key 10
  assign keyBus.roundIndex = 4'(`AES_ROUNDS) - round;

  assign mixIn = dataBlock[(3 - column) * 32 +: 32];

  // InvShiftRows and InvSubBytes together
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        // Row r rotates right by r columns
        shiftSub[(15 - 4 * c - r) * 8 +: 8] =
          aes_pkg::invSbox(dataBlock[(15 - 4 * ((c - r + 4) % 4) - r) * 8 +: 8]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      coreState <= aes_pkg::IDLE;
      round     <= 4'd0;
      column    <= 2'd0;
      msgOut    <= '0;
    end else begin
      case (coreState)
        aes_pkg::IDLE: begin
          if (run) begin
            round     <= 4'd0;
            coreState <= aes_pkg::KEY_EXPAND;
          end
        end
        aes_pkg::KEY_EXPAND: begin
          if (keyBus.keysReady) begin
            coreState <= aes_pkg::ADD_INIT;
          end
        end
        aes_pkg::ADD_INIT: begin
          round     <= 4'd1;
          coreState <= aes_pkg::SHIFT_SUB;
        end
        aes_pkg::SHIFT_SUB: begin
          coreState <= aes_pkg::ADD_KEY;
        end
        aes_pkg::ADD_KEY: begin
          column <= 2'd0;
          // Last round has no InvMixColumns
          if (round == 4'(`AES_ROUNDS)) begin
            coreState <= aes_pkg::DONE;
          end else begin
            coreState <= aes_pkg::MIX_COL;
          end
        end
        aes_pkg::MIX_COL: begin
          column <= column + 2'd1;
          if (column == 2'd3) begin
            round     <= round + 4'd1;
            coreState <= aes_pkg::SHIFT_SUB;
          end
        end
        aes_pkg::DONE: begin
          msgOut    <= dataBlock;
          coreState <= aes_pkg::IDLE;
        end
        default: begin
          coreState <= aes_pkg::IDLE;
        end
      endcase
    end
  end

  // State register datapath
  always_ff @(posedge clk) begin
    case (coreState)
      aes_pkg::IDLE: begin
        if (run) begin
          dataBlock <= msgIn;
        end
      end
      aes_pkg::ADD_INIT, aes_pkg::ADD_KEY: begin
        dataBlock <= dataBlock ^ keyBus.roundKey;
      end
      aes_pkg::SHIFT_SUB: begin
        dataBlock <= shiftSub;
      end
      aes_pkg::MIX_COL: begin
        dataBlock[(3 - column) * 32 +: 32] <= mixOut;
      end
      default: begin
      end
    endcase
  end

endmodule

/* design/aesDecryptTop.sv */
/*
  AES-128 decryption engine top with run strobe and ready level
*/

`timescale 1ns/10ps

module aesDecryptTop (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            run,
  input  aes_pkg::block_t key,
  input  aes_pkg::block_t msgIn,
  output aes_pkg::block_t msgOut,
  output logic            ready
);

  aes_pkg::word_t mixIn;
  aes_pkg::word_t mixOut;

  aesKeyIf keyBus ();

  aesDecryptCore aesDecryptCore_i (
    .clk     (clk),
    .reset_n (reset_n),
    .run     (run),
    .msgIn   (msgIn),
    .keyBus  (keyBus.core),
    .mixIn   (mixIn),
    .mixOut  (mixOut),
    .msgOut  (msgOut),
    .ready   (ready)
  );

  aesKeySchedule aesKeySchedule_i (
    .clk     (clk),
    .reset_n (reset_n),
    .key     (key),
    .keyBus  (keyBus.sched)
  );

  aesInvMixColumn aesInvMixColumn_i (
    .in  (mixIn),
    .out (mixOut)
  );

endmodule

/* design/aesInvMixColumn.sv */
/*
  Inverse MixColumns on one column over GF(2^8)
*/

`timescale 1ns/10ps

module aesInvMixColumn (
  input  aes_pkg::word_t in,
  output aes_pkg::word_t out
);

  // First matrix row, later rows are rotations of it
  localparam logic [3:0] coefRow [4] = '{4'he, 4'hb, 4'hd, 4'h9};

  function automatic logic [7:0] xtime(input logic [7:0] a);
    return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  endfunction

  // Coefficient bits select a, 2a, 4a and 8a
  function automatic logic [7:0] gfMul(input logic [7:0] a, input logic [3:0] coef);
    logic [7:0] a2;
    logic [7:0] a4;
    logic [7:0] a8;
    a2 = xtime(a);
    a4 = xtime(a2);
    a8 = xtime(a4);
    return ({8{coef[0]}} & a) ^ ({8{coef[1]}} & a2) ^
           ({8{coef[2]}} & a4) ^ ({8{coef[3]}} & a8);
  endfunction

  always_comb begin
    logic [7:0] acc;
    for (int i = 0; i < 4; i++) begin
      acc = 8'h00;
      for (int j = 0; j < 4; j++) begin
        acc = acc ^ gfMul(in[31 - 8 * j -: 8], coefRow[(j - i + 4) % 4]);
      end
      out[31 - 8 * i -: 8] = acc;
    end
  end

endmodule

/* design/aesKeyIf.sv */
/*
  Link between the decryption core and the key schedule
*/

`timescale 1ns/10ps

interface aesKeyIf;

  logic            start;
  logic            keysReady;
  logic [3:0]      roundIndex;
  aes_pkg::block_t roundKey;

  modport sched (input start, input roundIndex, output keysReady, output roundKey);

  modport core (output start, output roundIndex, input keysReady, input roundKey);

endinterface

/* design/aesKeySchedule.sv */
/*
  AES-128 key expansion, one round key per cycle into an
  eleven-entry store that the core reads by index
*/

`timescale 1ns/10ps
`include "aes_defines.svh"

module aesKeySchedule (
  input  logic            clk,
  input  logic            reset_n,
  input  aes_pkg::block_t key,
  aesKeyIf.sched          keyBus
);

  aes_pkg::block_t roundKeys [`AES_KEY_WORDS];
  aes_pkg::block_t prevKey;
  aes_pkg::block_t nextKey;
  aes_pkg::word_t  subWord;
  logic [7:0]      rcon;
  logic [3:0]      keyCount;
  logic            expanding;
  logic            keysDone;

  assign prevKey = roundKeys[keyCount - 4'd1];

  always_comb begin
    case (keyCount)
      4'd1:    rcon = 8'h01;
      4'd2:    rcon = 8'h02;
      4'd3:    rcon = 8'h04;
      4'd4:    rcon = 8'h08;
      4'd5:    rcon = 8'h10;
      4'd6:    rcon = 8'h20;
      4'd7:    rcon = 8'h40;
      4'd8:    rcon = 8'h80;
      4'd9:    rcon = 8'h1b;
      4'd10:   rcon = 8'h36;
      default: rcon = 8'h00;
    endcase
  end

  always_comb begin
    // RotWord then SubWord on the last column
    subWord = {aes_pkg::sbox(prevKey[23:16]), aes_pkg::sbox(prevKey[15:8]),
               aes_pkg::sbox(prevKey[7:0]), aes_pkg::sbox(prevKey[31:24])};
    nextKey[127:96] = prevKey[127:96] ^ subWord ^ {rcon, 24'h000000};
    nextKey[95:64]  = prevKey[95:64] ^ nextKey[127:96];
    nextKey[63:32]  = prevKey[63:32] ^ nextKey[95:64];
    nextKey[31:0]   = prevKey[31:0] ^ nextKey[63:32];
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      keyCount  <= 4'd0;
      expanding <= 1'b0;
      keysDone  <= 1'b0;
    end else if (keyBus.start) begin
      keyCount  <= 4'd1;
      expanding <= 1'b1;
      keysDone  <= 1'b0;
    end else if (expanding) begin
      if (keyCount == 4'(`AES_ROUNDS)) begin
        expanding <= 1'b0;
        keysDone  <= 1'b1;
      end else begin
        keyCount <= keyCount + 4'd1;
      end
    end
  end

  // Key store, cipher key lands in entry 0 on the start edge
  always_ff @(posedge clk) begin
    if (keyBus.start) begin
      roundKeys[0] <= key;
    end else if (expanding) begin
      roundKeys[keyCount] <= nextKey;
    end
  end

  // High already in the step that writes the last key, so the core moves on as it lands
  assign keyBus.keysReady = keysDone | (expanding && keyCount == 4'(`AES_ROUNDS));
  assign keyBus.roundKey  = roundKeys[keyBus.roundIndex];

endmodule

/* design/aes_defines.svh */
/*
  AES-128 round and key-store sizes
*/

`ifndef AES_DEFINES_SVH
`define AES_DEFINES_SVH

// Inverse rounds for a 128-bit key
`define AES_ROUNDS 10

// Round keys held by the key schedule, initial key included
`define AES_KEY_WORDS 11

`endif

/* design/aes_pkg.sv */
/*
  AES shared types and byte substitution tables.
  Byte 0 of a block sits in the most significant bits, as in FIPS-197.
*/

package aes_pkg;

  typedef logic [127:0] block_t;
  typedef logic [31:0]  word_t;

  // Decryption core FSM
  typedef enum logic [2:0] {
    IDLE,
    KEY_EXPAND,
    ADD_INIT,
    SHIFT_SUB,
    ADD_KEY,
    MIX_COL,
    DONE
  } coreState_t;

  // Forward S-box, entry 0 in the top byte
  localparam logic [2047:0] sboxTable = {
    128'h637c777b_f26b6fc5_3001672b_fed7ab76,
    128'hca82c97d_fa5947f0_add4a2af_9ca472c0,
    128'hb7fd9326_363ff7cc_34a5e5f1_71d83115,
    128'h04c723c3_1896059a_071280e2_eb27b275,
    128'h09832c1a_1b6e5aa0_523bd6b3_29e32f84,
    128'h53d100ed_20fcb15b_6acbbe39_4a4c58cf,
    128'hd0efaafb_434d3385_45f9027f_503c9fa8,
    128'h51a3408f_929d38f5_bcb6da21_10fff3d2,
    128'hcd0c13ec_5f974417_c4a77e3d_645d1973,
    128'h60814fdc_222a9088_46eeb814_de5e0bdb,
    128'he0323a0a_4906245c_c2d3ac62_9195e479,
    128'he7c8376d_8dd54ea9_6c56f4ea_657aae08,
    128'hba78252e_1ca6b4c6_e8dd741f_4bbd8b8a,
    128'h703eb566_4803f60e_613557b9_86c11d9e,
    128'he1f89811_69d98e94_9b1e87e9_ce5528df,
    128'h8ca1890d_bfe64268_41992d0f_b054bb16
  };

  // Inverse S-box, same layout
  localparam logic [2047:0] invSboxTable = {
    128'h52096ad5_3036a538_bf40a39e_81f3d7fb,
    128'h7ce33982_9b2fff87_348e4344_c4dee9cb,
    128'h547b9432_a6c2233d_ee4c950b_42fac34e,
    128'h082ea166_28d924b2_765ba249_6d8bd125,
    128'h72f8f664_86689816_d4a45ccc_5d65b692,
    128'h6c704850_fdedb9da_5e154657_a78d9d84,
    128'h90d8ab00_8cbcd30a_f7e45805_b8b34506,
    128'hd02c1e8f_ca3f0f02_c1afbd03_01138a6b,
    128'h3a911141_4f67dcea_97f2cfce_f0b4e673,
    128'h96ac7422_e7ad3585_e2f937e8_1c75df6e,
    128'h47f11a71_1d29c589_6fb7620e_aa18be1b,
    128'hfc563e4b_c6d27920_9adbc0fe_78cd5af4,
    128'h1fdda833_8807c731_b1121059_2780ec5f,
    128'h60517fa9_19b54a0d_2de57a9f_93c99cef,
    128'ha0e03b4d_ae2af5b0_c8ebbb3c_83539961,
    128'h172b047e_ba77d626_e1691463_55210c7d
  };

  function automatic logic [7:0] sbox(input logic [7:0] b);
    return sboxTable[(255 - b) * 8 +: 8];
  endfunction

  function automatic logic [7:0] invSbox(input logic [7:0] b);
    return invSboxTable[(255 - b) * 8 +: 8];
  endfunction

endpackage

/* files.f */
+incdir+design
design/aes_pkg.sv
design/aesKeyIf.sv
design/aesKeySchedule.sv
design/aesInvMixColumn.sv
design/aesDecryptCore.sv
design/aesDecryptTop.sv
verif/aesDecrypt_sva.sv
verif/aesDecryptTb.sv

/* verif/aesDecryptTb.sv */
/*
  Testbench for the AES-128 decryption engine. Runs FIPS-197
  known-answer vectors, with random filler on the inputs while busy
*/

`timescale 1ns/10ps

module aesDecryptTb;

  logic            clk;
  logic            reset_n;
  logic            run;
  aes_pkg::block_t key;
  aes_pkg::block_t msgIn;
  aes_pkg::block_t msgOut;
  logic            ready;

  int              checkErrors;
  int              timeouts;
  int              totalErrors;
  integer          seed;

  aesDecryptTop aesDecryptTop_i (
    .clk     (clk),
    .reset_n (reset_n),
    .run     (run),
    .key     (key),
    .msgIn   (msgIn),
    .msgOut  (msgOut),
    .ready   (ready)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Random inputs while busy, stray run pulses included
  task automatic driveNoise();
    msgIn = {$random(seed), $random(seed), $random(seed), $random(seed)};
    key   = {$random(seed), $random(seed), $random(seed), $random(seed)};
    run   = 1'($random(seed));
  endtask

  task automatic checkBlock(input string name, input aes_pkg::block_t expected,
                            input aes_pkg::block_t actual);
    if (actual !== expected) begin
      checkErrors++;
      $display("MISMATCH %s: expected %032h, actual %032h", name, expected, actual);
    end
  endtask

  task automatic waitReady(input bit noisy, output bit seen);
    seen = 1'b0;
    for (int cycle = 0; cycle < 200 && !seen; cycle++) begin
      @(posedge clk);
      #1;
      if (ready) begin
        seen = 1'b1;
        run  = 1'b0;
      end else if (noisy) begin
        driveNoise();
      end
    end
    if (!seen) begin
      timeouts++;
      $display("ERROR: timeout waiting for ready");
    end
  endtask

  task automatic decryptBlock(input string name, input aes_pkg::block_t keyValue,
                              input aes_pkg::block_t cipher,
                              input aes_pkg::block_t expected, input bit noisy);
    bit seen;
    key   = keyValue;
    msgIn = cipher;
    run   = 1'b1;
    @(posedge clk);
    #1;
    run = 1'b0;
    if (noisy) begin
      driveNoise();
    end
    waitReady(noisy, seen);
    if (seen) begin
      checkBlock(name, expected, msgOut);
    end
  endtask

  initial begin
    seed        = 32'h71f6;
    checkErrors = 0;
    timeouts    = 0;
    reset_n     = 1'b0;
    run         = 1'b0;
    key         = '0;
    msgIn       = '0;
    repeat (3) @(posedge clk);
    #1;
    reset_n = 1'b1;

    if (ready !== 1'b1) begin
      checkErrors++;
      $display("MISMATCH reset ready: expected 1, actual %b", ready);
    end
    checkBlock("reset msgOut", '0, msgOut);

    // Appendix C.1 then Appendix B back to back, the second with busy filler
    decryptBlock("fips197 C.1", 128'h000102030405060708090a0b0c0d0e0f,
                 128'h69c4e0d86a7b0430d8cdb78070b4c55a,
                 128'h00112233445566778899aabbccddeeff, 1'b0);
    decryptBlock("fips197 B", 128'h2b7e151628aed2a6abf7158809cf4f3c,
                 128'h3925841d02dc09fbdc118597196a0b32,
                 128'h3243f6a8885a308d313198a2e0370734, 1'b1);

    // Last latency samples land on the next edges
    repeat (4) @(posedge clk);
    totalErrors = checkErrors + timeouts + aesDecryptTop_i.aesDecrypt_sva_i.failCount;
    $display("Errors: %0d check, %0d assertion, %0d timeout", checkErrors,
             aesDecryptTop_i.aesDecrypt_sva_i.failCount, timeouts);
    if (totalErrors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* verif/aesDecrypt_sva.sv */
/*
  Timing checks on the AES decryption engine ports, bound to the top
*/

`timescale 1ns/10ps

module aesDecrypt_sva (
  input logic            clk,
  input logic            reset_n,
  input logic            run,
  input logic            ready,
  input aes_pkg::block_t msgOut
);

  int failCount = 0;

  // Engine comes out of reset idle with a cleared output
  resetState: assert property (@(posedge clk) !reset_n |=> ready && msgOut == '0)
    else begin
      failCount++;
      $error("engine not idle with cleared output after reset");
    end

  // Ready drops right after an accepted run and is back 69 samples later
  runLatency: assert property (@(posedge clk) disable iff (!reset_n)
    run && ready |=> !ready ##68 ready)
    else begin
      failCount++;
      $error("ready did not follow the 68 cycle run latency");
    end

  // Ready only returns where a run was accepted 69 samples earlier
  readyReturn: assert property (@(posedge clk) disable iff (!reset_n)
    $rose(ready) |-> $past(run && ready, 69))
    else begin
      failCount++;
      $error("ready returned at the wrong time");
    end

  busyStable: assert property (@(posedge clk) disable iff (!reset_n)
    !ready |-> $stable(msgOut))
    else begin
      failCount++;
      $error("msgOut changed while the engine was busy");
    end

endmodule

bind aesDecryptTop aesDecrypt_sva aesDecrypt_sva_i (
  .clk     (clk),
  .reset_n (reset_n),
  .run     (run),
  .ready   (ready),
  .msgOut  (msgOut)
);
